// File: hw/fetch_types_pkg.sv
/* Fetch front end core-side types
   Warp id, program counter, thread mask, issue serial number and instruction word */
package fetch_types_pkg;

    // Widths of the core-side fields
    localparam int WID_W   = 2;
    localparam int PC_W    = 16;
    localparam int TMASK_W = 4;
    localparam int UUID_W  = 8;
    localparam int INSTR_W = 32;

    // Warp id, sized for four warps
    typedef logic [WID_W-1:0] wid_t;

    // Byte program counter
    typedef logic [PC_W-1:0] pc_t;

    // One bit per thread of a warp
    typedef logic [TMASK_W-1:0] tmask_t;

    // Issue serial number, wraps around
    typedef logic [UUID_W-1:0] uuid_t;

    typedef logic [INSTR_W-1:0] instr_t;

endpackage

// File: hw/imem_bus_pkg.sv
/* Instruction memory bus types
   Word address, request tag, data word and loader address map */
package imem_bus_pkg;

    localparam int WADDR_W = 10;
    localparam int MTAG_W  = 10;
    localparam int MDATA_W = 32;

    // Word address into the instruction RAM
    typedef logic [WADDR_W-1:0] waddr_t;

    // Request tag, uuid in the upper bits and warp id in the lower bits
    typedef logic [MTAG_W-1:0] mtag_t;

    typedef logic [MDATA_W-1:0] mdata_t;

    // Byte address of the loader launch register
    localparam logic [31:0] LAUNCH_ADDR = 32'h0000_1000;

endpackage

// File: hw/warp_sched.sv
/* Round-robin warp scheduler
   Holds PC and thread mask per warp and offers active warps for fetch */
`timescale 1ns/10ps

module warp_sched import fetch_types_pkg::*; #(
    parameter int NUM_WARPS = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   launch,
    input  pc_t    launch_pc,
    input  tmask_t launch_tmask,
    output logic   sched_valid,
    input  logic   sched_ready,
    output wid_t   sched_wid,
    output pc_t    sched_pc,
    output tmask_t sched_tmask,
    output uuid_t  sched_uuid
);

    typedef enum logic {
        SCHED_IDLE,
        SCHED_RUN
    } sched_state_t;

    sched_state_t         state;
    pc_t                  warp_pc    [NUM_WARPS];
    tmask_t               warp_tmask [NUM_WARPS];
    logic [NUM_WARPS-1:0] active;
    uuid_t                uuid;
    wid_t                 last_wid;
    wid_t                 next_wid;
    logic                 found;
    logic                 sched_fire;

    // Search starts at the warp after the last granted one
    always_comb begin
        int idx;
        found    = 1'b0;
        next_wid = '0;
        for (int i = 1; i <= NUM_WARPS; i++) begin
            idx = (int'(last_wid) + i) % NUM_WARPS;
            if (!found && active[idx]) begin
                found    = 1'b1;
                next_wid = wid_t'(idx);
            end
        end
    end

    assign sched_valid = (state == SCHED_RUN) && found;
    assign sched_fire  = sched_valid && sched_ready;
    assign sched_wid   = next_wid;
    assign sched_pc    = warp_pc[next_wid];
    assign sched_tmask = warp_tmask[next_wid];
    assign sched_uuid  = uuid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= SCHED_IDLE;
            active   <= '0;
            last_wid <= wid_t'(NUM_WARPS - 1);
            uuid     <= '0;
        end else if (launch) begin
            // Warp 0 goes first after a launch
            state    <= SCHED_RUN;
            active   <= '1;
            last_wid <= wid_t'(NUM_WARPS - 1);
        end else if (sched_fire) begin
            last_wid <= next_wid;
            uuid     <= uuid + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (launch) begin
                warp_pc[w]    <= launch_pc;
                warp_tmask[w] <= launch_tmask;
            end else if (sched_fire && (next_wid == wid_t'(w))) begin
                warp_pc[w] <= warp_pc[w] + pc_t'(4);
            end
        end
    end

endmodule

// File: hw/fetch_unit.sv
/* Instruction fetch unit
   Turns scheduled warps into tagged memory reads and responses into fetch records */
`timescale 1ns/10ps

module fetch_unit import fetch_types_pkg::*, imem_bus_pkg::*; #(
    parameter int NUM_WARPS = 4,
    parameter int IBUF_SIZE = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sched_valid,
    output logic                 sched_ready,
    input  wid_t                 sched_wid,
    input  pc_t                  sched_pc,
    input  tmask_t               sched_tmask,
    input  uuid_t                sched_uuid,
    output logic                 freq_valid,
    input  logic                 freq_ready,
    output waddr_t               freq_addr,
    output mtag_t                freq_tag,
    input  logic                 frsp_valid,
    output logic                 frsp_ready,
    input  mdata_t               frsp_data,
    input  mtag_t                frsp_tag,
    input  logic [NUM_WARPS-1:0] ibuf_pop,
    output logic                 fetch_valid,
    input  logic                 fetch_ready,
    output wid_t                 fetch_wid,
    output pc_t                  fetch_pc,
    output tmask_t               fetch_tmask,
    output instr_t               fetch_instr,
    output uuid_t                fetch_uuid
);

    localparam int SLOT_W = (IBUF_SIZE > 1) ? $clog2(IBUF_SIZE) : 1;
    localparam int CNT_W  = $clog2(IBUF_SIZE + 1);

    logic                 sched_fire;
    logic                 freq_fire;
    logic                 fetch_fire;
    wid_t                 rsp_wid;
    uuid_t                rsp_uuid;
    logic [NUM_WARPS-1:0] sched_hit;
    logic [NUM_WARPS-1:0] rsp_hit;
    logic [NUM_WARPS-1:0] pend_full;
    logic [CNT_W-1:0]     pend_cnt [NUM_WARPS];

    // Tag store, one slot per outstanding request of each warp
    pc_t                  tag_pc    [NUM_WARPS][IBUF_SIZE];
    tmask_t               tag_tmask [NUM_WARPS][IBUF_SIZE];
    logic [SLOT_W-1:0]    wr_slot   [NUM_WARPS];
    logic [SLOT_W-1:0]    rd_slot   [NUM_WARPS];

    // Two-entry request buffer
    waddr_t               rbuf_addr [2];
    mtag_t                rbuf_tag  [2];
    logic                 rbuf_wr;
    logic                 rbuf_rd;
    logic [1:0]           rbuf_cnt;

    function automatic logic [SLOT_W-1:0] slot_next(input logic [SLOT_W-1:0] s);
        return (int'(s) == IBUF_SIZE - 1) ? '0 : s + 1'b1;
    endfunction

    assign sched_fire = sched_valid && sched_ready;
    assign freq_fire  = freq_valid && freq_ready;
    assign fetch_fire = fetch_valid && fetch_ready;

    assign {rsp_uuid, rsp_wid} = frsp_tag;

    always_comb begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            sched_hit[w] = sched_fire && (sched_wid == wid_t'(w));
            rsp_hit[w]   = fetch_fire && (rsp_wid == wid_t'(w));
            pend_full[w] = (pend_cnt[w] == CNT_W'(IBUF_SIZE));
        end
    end

    // Hold back a warp whose instruction buffer slots are all claimed
    assign sched_ready = (rbuf_cnt != 2'd2) && !pend_full[sched_wid];

    // Pending counts and tag store slot pointers
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (!rst_n) begin
                pend_cnt[w] <= '0;
                wr_slot[w]  <= '0;
                rd_slot[w]  <= '0;
            end else begin
                if (sched_hit[w] && !ibuf_pop[w]) begin
                    pend_cnt[w] <= pend_cnt[w] + 1'b1;
                end else if (!sched_hit[w] && ibuf_pop[w]) begin
                    pend_cnt[w] <= pend_cnt[w] - 1'b1;
                end
                if (sched_hit[w]) begin
                    wr_slot[w] <= slot_next(wr_slot[w]);
                end
                if (rsp_hit[w]) begin
                    rd_slot[w] <= slot_next(rd_slot[w]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sched_fire) begin
            tag_pc[sched_wid][wr_slot[sched_wid]]    <= sched_pc;
            tag_tmask[sched_wid][wr_slot[sched_wid]] <= sched_tmask;
            rbuf_addr[rbuf_wr] <= waddr_t'(sched_pc >> 2);
            rbuf_tag[rbuf_wr]  <= mtag_t'({sched_uuid, sched_wid});
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rbuf_wr  <= 1'b0;
            rbuf_rd  <= 1'b0;
            rbuf_cnt <= '0;
        end else begin
            if (sched_fire) begin
                rbuf_wr <= ~rbuf_wr;
            end
            if (freq_fire) begin
                rbuf_rd <= ~rbuf_rd;
            end
            rbuf_cnt <= rbuf_cnt + {1'b0, sched_fire} - {1'b0, freq_fire};
        end
    end

    // Memory request straight from the buffer registers
    assign freq_valid = (rbuf_cnt != 2'd0);
    assign freq_addr  = rbuf_addr[rbuf_rd];
    assign freq_tag   = rbuf_tag[rbuf_rd];

    // Fetch record rebuilt from the response tag
    assign fetch_valid = frsp_valid;
    assign frsp_ready  = fetch_ready;
    assign fetch_wid   = rsp_wid;
    assign fetch_uuid  = rsp_uuid;
    assign fetch_pc    = tag_pc[rsp_wid][rd_slot[rsp_wid]];
    assign fetch_tmask = tag_tmask[rsp_wid][rd_slot[rsp_wid]];
    assign fetch_instr = instr_t'(frsp_data);

endmodule

// File: hw/axil_loader.sv
/* AXI4-Lite program loader
   Writes program words into the instruction RAM and starts warps on a launch write */
`timescale 1ns/10ps

module axil_loader import fetch_types_pkg::*, imem_bus_pkg::*; #(
    parameter int IMEM_DEPTH = 1024
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        lreq_valid,
    input  logic        lreq_ready,
    output waddr_t      lreq_addr,
    output mdata_t      lreq_data,
    output logic        launch,
    output pc_t         launch_pc,
    output tmask_t      launch_tmask
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_ISSUE,
        LD_RESP
    } ld_state_t;

    ld_state_t state;
    logic      aw_fire;
    logic      lreq_fire;
    logic      is_ram;
    logic      is_launch;
    logic      op_launch;
    logic      op_err;
    waddr_t    addr_q;
    mdata_t    data_q;

    // Address map: RAM words from zero, then the launch register
    assign is_launch = (awaddr == LAUNCH_ADDR);
    assign is_ram    = (awaddr < 32'(IMEM_DEPTH * 4));

    // AW and W are taken together; wstrb is not looked at
    assign aw_fire   = (state == LD_IDLE) && awvalid && wvalid;
    assign awready   = aw_fire;
    assign wready    = aw_fire;
    assign lreq_fire = lreq_valid && lreq_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= LD_IDLE;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (aw_fire) begin
                        state <= (is_ram || is_launch) ? LD_ISSUE : LD_RESP;
                    end
                end
                LD_ISSUE: begin
                    if (launch || lreq_fire) begin
                        state <= LD_RESP;
                    end
                end
                LD_RESP: begin
                    if (bready) begin
                        state <= LD_IDLE;
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            addr_q    <= waddr_t'(awaddr >> 2);
            data_q    <= wdata;
            op_launch <= is_launch;
            op_err    <= !(is_ram || is_launch);
        end
    end

    assign lreq_valid = (state == LD_ISSUE) && !op_launch;
    assign lreq_addr  = addr_q;
    assign lreq_data  = data_q;

    // Launch word: PC in the low half, thread mask just above it
    assign launch       = (state == LD_ISSUE) && op_launch;
    assign launch_pc    = data_q[$bits(pc_t)-1:0];
    assign launch_tmask = data_q[16 +: $bits(tmask_t)];

    assign bvalid = (state == LD_RESP);
    assign bresp  = op_err ? RESP_SLVERR : RESP_OKAY;

    // Read channel, every read is refused
    assign arready = !rvalid;
    assign rdata   = '0;
    assign rresp   = RESP_SLVERR;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

// File: hw/imem_arbiter.sv
/* Instruction RAM arbiter
   Round-robin between fetch reads and loader writes, read responses go to fetch */
`timescale 1ns/10ps

module imem_arbiter import imem_bus_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   freq_valid,
    output logic   freq_ready,
    input  waddr_t freq_addr,
    input  mtag_t  freq_tag,
    output logic   frsp_valid,
    input  logic   frsp_ready,
    output mdata_t frsp_data,
    output mtag_t  frsp_tag,
    input  logic   lreq_valid,
    output logic   lreq_ready,
    input  waddr_t lreq_addr,
    input  mdata_t lreq_data,
    output logic   mreq_valid,
    input  logic   mreq_ready,
    output logic   mreq_write,
    output waddr_t mreq_addr,
    output mdata_t mreq_wdata,
    output mtag_t  mreq_tag,
    input  logic   mrsp_valid,
    output logic   mrsp_ready,
    input  mdata_t mrsp_data,
    input  mtag_t  mrsp_tag
);

    logic loader_first;
    logic grant_f;
    logic grant_l;

    // A contested cycle goes to whichever side holds priority
    assign grant_f = freq_valid && (!lreq_valid || !loader_first);
    assign grant_l = lreq_valid && (!freq_valid || loader_first);

    assign mreq_valid = freq_valid || lreq_valid;
    assign mreq_write = grant_l;
    assign mreq_addr  = grant_l ? lreq_addr : freq_addr;
    assign mreq_wdata = grant_l ? lreq_data : '0;
    assign mreq_tag   = grant_l ? '0 : freq_tag;

    assign freq_ready = grant_f && mreq_ready;
    assign lreq_ready = grant_l && mreq_ready;

    // Priority flips only when both sides wanted the RAM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            loader_first <= 1'b0;
        end else if (freq_valid && lreq_valid && mreq_ready) begin
            loader_first <= ~loader_first;
        end
    end

    // Only fetch reads produce responses
    assign frsp_valid = mrsp_valid;
    assign frsp_data  = mrsp_data;
    assign frsp_tag   = mrsp_tag;
    assign mrsp_ready = frsp_ready;

endmodule

// File: hw/imem_ram.sv
/* Single-port instruction RAM with a one-entry registered read response */
`timescale 1ns/10ps

module imem_ram import imem_bus_pkg::*; #(
    parameter int IMEM_DEPTH = 1024
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   mreq_valid,
    output logic   mreq_ready,
    input  logic   mreq_write,
    input  waddr_t mreq_addr,
    input  mdata_t mreq_wdata,
    input  mtag_t  mreq_tag,
    output logic   mrsp_valid,
    input  logic   mrsp_ready,
    output mdata_t mrsp_data,
    output mtag_t  mrsp_tag
);

    mdata_t mem [IMEM_DEPTH];
    logic   req_fire;

    // Stall while a response waits for its consumer
    assign mreq_ready = !mrsp_valid || mrsp_ready;
    assign req_fire   = mreq_valid && mreq_ready;

    always_ff @(posedge clk) begin
        if (req_fire && mreq_write) begin
            mem[mreq_addr] <= mreq_wdata;
        end
        if (req_fire && !mreq_write) begin
            mrsp_data <= mem[mreq_addr];
            mrsp_tag  <= mreq_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mrsp_valid <= 1'b0;
        end else if (req_fire) begin
            mrsp_valid <= !mreq_write;
        end else if (mrsp_ready) begin
            mrsp_valid <= 1'b0;
        end
    end

endmodule

// File: hw/fetch_top.sv
/* Fetch front end top level
   Scheduler, fetch unit, program loader, arbiter and instruction RAM */
`timescale 1ns/10ps

module fetch_top import fetch_types_pkg::*, imem_bus_pkg::*; #(
    parameter int NUM_WARPS  = 4,
    parameter int IBUF_SIZE  = 2,
    parameter int IMEM_DEPTH = 1024
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [31:0]          awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,
    output logic                 bvalid,
    input  logic                 bready,
    output logic [1:0]           bresp,
    input  logic                 arvalid,
    output logic                 arready,
    input  logic [31:0]          araddr,
    output logic                 rvalid,
    input  logic                 rready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp,
    output logic                 fetch_valid,
    input  logic                 fetch_ready,
    output wid_t                 fetch_wid,
    output pc_t                  fetch_pc,
    output tmask_t               fetch_tmask,
    output instr_t               fetch_instr,
    output uuid_t                fetch_uuid,
    input  logic [NUM_WARPS-1:0] ibuf_pop
);

    logic   launch;
    pc_t    launch_pc;
    tmask_t launch_tmask;

    logic   sched_valid;
    logic   sched_ready;
    wid_t   sched_wid;
    pc_t    sched_pc;
    tmask_t sched_tmask;
    uuid_t  sched_uuid;

    logic   freq_valid;
    logic   freq_ready;
    waddr_t freq_addr;
    mtag_t  freq_tag;
    logic   frsp_valid;
    logic   frsp_ready;
    mdata_t frsp_data;
    mtag_t  frsp_tag;

    logic   lreq_valid;
    logic   lreq_ready;
    waddr_t lreq_addr;
    mdata_t lreq_data;

    logic   mreq_valid;
    logic   mreq_ready;
    logic   mreq_write;
    waddr_t mreq_addr;
    mdata_t mreq_wdata;
    mtag_t  mreq_tag;
    logic   mrsp_valid;
    logic   mrsp_ready;
    mdata_t mrsp_data;
    mtag_t  mrsp_tag;

    warp_sched #(
        .NUM_WARPS (NUM_WARPS)
    ) u_sched (
        .clk          (clk),
        .rst_n        (rst_n),
        .launch       (launch),
        .launch_pc    (launch_pc),
        .launch_tmask (launch_tmask),
        .sched_valid  (sched_valid),
        .sched_ready  (sched_ready),
        .sched_wid    (sched_wid),
        .sched_pc     (sched_pc),
        .sched_tmask  (sched_tmask),
        .sched_uuid   (sched_uuid)
    );

    fetch_unit #(
        .NUM_WARPS (NUM_WARPS),
        .IBUF_SIZE (IBUF_SIZE)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .sched_valid (sched_valid),
        .sched_ready (sched_ready),
        .sched_wid   (sched_wid),
        .sched_pc    (sched_pc),
        .sched_tmask (sched_tmask),
        .sched_uuid  (sched_uuid),
        .freq_valid  (freq_valid),
        .freq_ready  (freq_ready),
        .freq_addr   (freq_addr),
        .freq_tag    (freq_tag),
        .frsp_valid  (frsp_valid),
        .frsp_ready  (frsp_ready),
        .frsp_data   (frsp_data),
        .frsp_tag    (frsp_tag),
        .ibuf_pop    (ibuf_pop),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_wid   (fetch_wid),
        .fetch_pc    (fetch_pc),
        .fetch_tmask (fetch_tmask),
        .fetch_instr (fetch_instr),
        .fetch_uuid  (fetch_uuid)
    );

    axil_loader #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_loader (
        .clk          (clk),
        .rst_n        (rst_n),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .bvalid       (bvalid),
        .bready       (bready),
        .bresp        (bresp),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .lreq_valid   (lreq_valid),
        .lreq_ready   (lreq_ready),
        .lreq_addr    (lreq_addr),
        .lreq_data    (lreq_data),
        .launch       (launch),
        .launch_pc    (launch_pc),
        .launch_tmask (launch_tmask)
    );

    imem_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .freq_valid (freq_valid),
        .freq_ready (freq_ready),
        .freq_addr  (freq_addr),
        .freq_tag   (freq_tag),
        .frsp_valid (frsp_valid),
        .frsp_ready (frsp_ready),
        .frsp_data  (frsp_data),
        .frsp_tag   (frsp_tag),
        .lreq_valid (lreq_valid),
        .lreq_ready (lreq_ready),
        .lreq_addr  (lreq_addr),
        .lreq_data  (lreq_data),
        .mreq_valid (mreq_valid),
        .mreq_ready (mreq_ready),
        .mreq_write (mreq_write),
        .mreq_addr  (mreq_addr),
        .mreq_wdata (mreq_wdata),
        .mreq_tag   (mreq_tag),
        .mrsp_valid (mrsp_valid),
        .mrsp_ready (mrsp_ready),
        .mrsp_data  (mrsp_data),
        .mrsp_tag   (mrsp_tag)
    );

    imem_ram #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .mreq_valid (mreq_valid),
        .mreq_ready (mreq_ready),
        .mreq_write (mreq_write),
        .mreq_addr  (mreq_addr),
        .mreq_wdata (mreq_wdata),
        .mreq_tag   (mreq_tag),
        .mrsp_valid (mrsp_valid),
        .mrsp_ready (mrsp_ready),
        .mrsp_data  (mrsp_data),
        .mrsp_tag   (mrsp_tag)
    );

endmodule

// File: verif/tb_clkgen.sv
/* Testbench clock generator, 20 ns period */
`timescale 1ns/10ps

module tb_clkgen #(
    parameter real PERIOD = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

// File: verif/fetch_top_tb.sv
/* Fetch front end testbench
   Loads a program over AXI4-Lite, launches the warps and models the decode stage */
`timescale 1ns/10ps

module fetch_top_tb;

    localparam int NUM_WARPS   = 4;
    localparam int IBUF_SIZE   = 2;
    localparam int NUM_WORDS   = 64;
    localparam int NUM_RECORDS = 64;
    localparam int MAX_CYCLES  = 4000;

    logic        clk;
    logic        rst_n;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp;
    logic        fetch_valid, fetch_ready;
    logic [1:0]  fetch_wid;
    logic [15:0] fetch_pc;
    logic [3:0]  fetch_tmask;
    logic [31:0] fetch_instr;
    logic [7:0]  fetch_uuid;
    logic [NUM_WARPS-1:0] ibuf_pop;

    integer seed = 32'h721d_7faf;
    int     cycles = 0;
    int     rec_count = 0;
    int     exp_pc    [NUM_WARPS];
    int     last_uuid [NUM_WARPS];
    int     delivered [NUM_WARPS];
    int     popped    [NUM_WARPS];
    bit     seen_uuid [256];
    bit     hold_valid = 1'b0;
    logic [61:0] held;

    tb_clkgen u_clk (.clk(clk));

    fetch_top #(
        .NUM_WARPS (NUM_WARPS),
        .IBUF_SIZE (IBUF_SIZE)
    ) UUT (
        .clk (clk), .rst_n (rst_n),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
        .fetch_valid (fetch_valid), .fetch_ready (fetch_ready),
        .fetch_wid (fetch_wid), .fetch_pc (fetch_pc), .fetch_tmask (fetch_tmask),
        .fetch_instr (fetch_instr), .fetch_uuid (fetch_uuid),
        .ibuf_pop (ibuf_pop)
    );

    task automatic stop_run();
        $display("Something failed");
        $fatal(1);
    endtask

    // One AXI4-Lite write with AW and W offered together
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(posedge clk);
        while (!awready) @(posedge clk);
        assert (wready) else begin
            $display("FAIL wready got %h expected %h", wready, 1'b1);
            stop_run();
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(posedge clk);
        while (!bvalid) @(posedge clk);
        assert (bresp == exp_resp) else begin
            $display("FAIL bresp got %h expected %h at awaddr %h", bresp, exp_resp, addr);
            stop_run();
        end
    endtask

    task automatic axil_read(input logic [31:0] addr);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        arvalid <= 1'b0;
        @(posedge clk);
        while (!rvalid) @(posedge clk);
        assert (rresp == 2'b10) else begin
            $display("FAIL rresp got %h expected %h", rresp, 2'b10);
            stop_run();
        end
        assert (rdata == 32'h0) else begin
            $display("FAIL rdata got %h expected %h", rdata, 32'h0);
            stop_run();
        end
    endtask

    initial begin
        rst_n = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = 4'hf;
        bready = 1'b1;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b1;
        fetch_ready = 1'b0;
        ibuf_pop = '0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            exp_pc[w] = 0;
            last_uuid[w] = -1;
            delivered[w] = 0;
            popped[w] = 0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // Reads are always refused
        axil_read(32'h0000_0000);
        for (int i = 0; i < NUM_WORDS; i++) begin
            axil_write(32'(i * 4), 32'(i) ^ 32'ha5a5_0000, 2'b00);
        end
        // Unmapped write whose low address bits alias word 0
        axil_write(32'h0000_2000, 32'hdead_beef, 2'b10);
        // Launch at PC 0 with thread mask 1011
        axil_write(32'h0000_1000, 32'h000b_0000, 2'b00);
        while (rec_count < NUM_RECORDS) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles with %0d records", cycles, rec_count);
            stop_run();
        end
    end

    // Decode stage model and record checks
    always @(posedge clk) begin
        int w;
        logic [NUM_WARPS-1:0] pop;
        logic [31:0] exp_instr;
        if (rst_n) begin
            if (hold_valid) begin
                assert (fetch_valid) else begin
                    $display("FAIL fetch_valid got %h expected %h", fetch_valid, 1'b1);
                    stop_run();
                end
                assert ({fetch_wid, fetch_pc, fetch_tmask, fetch_instr, fetch_uuid} == held)
                else begin
                    $display("FAIL fetch record got %h expected %h",
                             {fetch_wid, fetch_pc, fetch_tmask, fetch_instr, fetch_uuid}, held);
                    stop_run();
                end
            end
            hold_valid = fetch_valid && !fetch_ready;
            held = {fetch_wid, fetch_pc, fetch_tmask, fetch_instr, fetch_uuid};

            if (fetch_valid && fetch_ready) begin
                w = int'(fetch_wid);
                exp_instr = 32'(exp_pc[w] >> 2) ^ 32'ha5a5_0000;
                assert (fetch_pc == 16'(exp_pc[w])) else begin
                    $display("FAIL fetch_pc got %h expected %h", fetch_pc, 16'(exp_pc[w]));
                    stop_run();
                end
                assert (fetch_tmask == 4'b1011) else begin
                    $display("FAIL fetch_tmask got %h expected %h", fetch_tmask, 4'b1011);
                    stop_run();
                end
                assert (fetch_instr == exp_instr) else begin
                    $display("FAIL fetch_instr got %h expected %h", fetch_instr, exp_instr);
                    stop_run();
                end
                assert (!seen_uuid[fetch_uuid] && int'(fetch_uuid) > last_uuid[w]) else begin
                    $display("FAIL fetch_uuid got %h after %h", fetch_uuid, last_uuid[w]);
                    stop_run();
                end
                seen_uuid[fetch_uuid] = 1'b1;
                last_uuid[w] = int'(fetch_uuid);
                exp_pc[w] = exp_pc[w] + 4;
                delivered[w] = delivered[w] + 1;
                rec_count = rec_count + 1;
                assert (delivered[w] - popped[w] <= IBUF_SIZE) else begin
                    $display("FAIL warp %0d records in buffer got %h limit %h", w,
                             delivered[w] - popped[w], IBUF_SIZE);
                    stop_run();
                end
            end

            // Pop held records after a random delay
            pop = '0;
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (delivered[i] > popped[i] && ($random(seed) & 3) == 0) begin
                    pop[i] = 1'b1;
                    popped[i] = popped[i] + 1;
                end
            end
            ibuf_pop <= pop;
            fetch_ready <= (rec_count < NUM_RECORDS) && (($random(seed) & 3) != 0);
        end
    end

endmodule

// File: fetch_top.f
hw/fetch_types_pkg.sv
hw/imem_bus_pkg.sv
hw/warp_sched.sv
hw/fetch_unit.sv
hw/axil_loader.sv
hw/imem_arbiter.sv
hw/imem_ram.sv
hw/fetch_top.sv
verif/tb_clkgen.sv
verif/fetch_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the log
verilator --binary --assert --timing -f fetch_top.f --top-module fetch_top_tb \
    -o sim_fetch_top > build.log 2>&1 \
    && ./obj_dir/sim_fetch_top > sim.log 2>&1 \
    && grep -q "Everything OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
